/* include/sce_defs.svh */
// ------------------------------
// SCE guard sizes, IDs and timing constants
// ------------------------------

`ifndef SCE_DEFS_SVH
`define SCE_DEFS_SVH

// Width of one core's user-privilege word
`define SCE_CORE_USER_W 8

// Trust vector size, top bit is tied to 1
`define SCE_TS_COUNT 128

// HMAC key ID and request key slot widths
`define SCE_KEY_ID_W 10
`define SCE_SLOT_W 7

// Bus master IDs of the two cores
`define SCE_MID_W 4
`define SCE_MID_CM7 4'h1
`define SCE_MID_VEX 4'h4

// Cycles after reset release until the one-time RAM clear
`define SCE_RAMCLR_STEPS 3

`endif

/* verilog/sce_pkg.sv */
// ------------------------------
// SCE guard shared types
// ------------------------------

`default_nettype none

`include "sce_defs.svh"

package sce_pkg;

    // One core's user-privilege word
    typedef logic [`SCE_CORE_USER_W-1:0] core_user_t;

    // Decoded engine mode, sec covers both encodings 2 and 3
    typedef struct packed {
        logic non;
        logic xls;
        logic sec;
    } sce_mode_t;

    // Locked owner: sel 0 is CM7, sel 1 is Vex
    typedef struct packed {
        logic       sel;
        core_user_t user;
    } sce_owner_t;

    // One strobed bus request, 77 bits
    typedef struct packed {
        logic                   valid;
        logic [`SCE_MID_W-1:0]  mid;
        logic                   write;
        logic [`SCE_SLOT_W-1:0] key_slot;
        logic [31:0]            addr;
        logic [31:0]            wdata;
    } sce_bus_req_t;

    // HMAC verdict strobes with the key they apply to
    typedef struct packed {
        logic                     pass;
        logic                     fail;
        logic [`SCE_KEY_ID_W-1:0] kid;
    } sce_hmac_t;

    typedef logic [`SCE_TS_COUNT-1:0] sce_trust_t;

endpackage

`default_nettype wire

/* verilog/sce_owner_ctrl.sv */
// ------------------------------
// SCE owner control: mode decode, owner lock,
// engine reset and one-time RAM clear
// ------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "sce_defs.svh"

module sce_owner_ctrl (
    input  bit                    clk,
    input  bit                    reset,
    input  bit [1:0]              sce_mode,
    input  bit [1:0]              dev_mode,
    input  sce_pkg::core_user_t   core_user_cm7,
    input  sce_pkg::core_user_t   core_user_vex,
    input  sce_pkg::sce_bus_req_t bus_req,
    input  bit                    ar_reset,
    input  bit                    ar_clrram,
    output sce_pkg::sce_mode_t    mode,
    output sce_pkg::sce_owner_t   owner,
    output bit                    engine_reset_n,
    output bit                    ram_clear
);

    import sce_pkg::*;

    logic [1:0] prev_mode;
    logic       lock_evt;
    logic       mode_quit;
    logic       req_cm7;
    logic       req_vex;
    sce_owner_t cand;

    // Init flags fill with ones from the bottom after reset
    logic [`SCE_RAMCLR_STEPS:0] init_flags;

    // Mode decode
    assign mode.non = (sce_mode == 2'd0);
    assign mode.xls = (sce_mode == 2'd1);
    assign mode.sec = sce_mode[1];

    always_ff @(posedge clk) begin
        if (reset) begin
            prev_mode <= 2'd0;
        end else begin
            prev_mode <= sce_mode;
        end
    end

    // Leaving open mode locks the owner
    assign lock_evt = (prev_mode == 2'd0) && (sce_mode != prev_mode);

    // Leaving any other mode resets the engine
    assign mode_quit = !dev_mode[1] && (prev_mode != 2'd0) && (sce_mode != prev_mode);

    // Owner candidate follows the last core that addressed the engine
    assign req_cm7 = bus_req.valid && (bus_req.mid == `SCE_MID_CM7);
    assign req_vex = bus_req.valid && (bus_req.mid == `SCE_MID_VEX);

    always_ff @(posedge clk) begin
        if (reset) begin
            cand <= '0;
        end else if (req_cm7) begin
            cand.sel  <= 1'b0;
            cand.user <= core_user_cm7;
        end else if (req_vex) begin
            cand.sel  <= 1'b1;
            cand.user <= core_user_vex;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            owner <= '0;
        end else if (lock_evt) begin
            owner <= cand;
        end
    end

    assign engine_reset_n = !(mode_quit || ar_reset);

    always_ff @(posedge clk) begin
        if (reset) begin
            init_flags <= '0;
        end else begin
            init_flags <= {init_flags[`SCE_RAMCLR_STEPS-1:0], 1'b1};
        end
    end

    // One pulse when the low flags are full but the top one is not yet set
    assign ram_clear = (init_flags == {1'b0, {`SCE_RAMCLR_STEPS{1'b1}}}) || ar_clrram;

endmodule

`default_nettype wire

/* verilog/sce_trust_state.sv */
// ------------------------------
// SCE trust vector, per-key bits set or
// cleared by HMAC verdicts in secure mode
// ------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "sce_defs.svh"

module sce_trust_state (
    input  bit                  clk,
    input  bit                  reset,
    input  sce_pkg::sce_mode_t  mode,
    input  sce_pkg::sce_hmac_t  hmac,
    output sce_pkg::sce_trust_t trust
);

    // Only the lower bits are stored
    logic [`SCE_TS_COUNT-2:0] ts_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            ts_q <= '0;
        end else if (mode.sec) begin
            for (int k = 0; k < `SCE_TS_COUNT - 1; k++) begin
                // Pass wins when both strobes hit the same key
                if (hmac.kid == k) begin
                    if (hmac.pass) begin
                        ts_q[k] <= 1'b1;
                    end else if (hmac.fail) begin
                        ts_q[k] <= 1'b0;
                    end
                end
            end
        end
    end

    // Top bit always trusted
    assign trust = {1'b1, ts_q};

endmodule

`default_nettype wire

/* verilog/sce_access_gate.sv */
// ------------------------------
// SCE access gate: owner and trust check,
// forwards or blocks each bus request
// ------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "sce_defs.svh"

module sce_access_gate (
    input  sce_pkg::sce_mode_t    mode,
    input  sce_pkg::sce_owner_t   owner,
    input  sce_pkg::core_user_t   core_user_cm7,
    input  sce_pkg::core_user_t   core_user_vex,
    input  sce_pkg::sce_trust_t   trust,
    input  bit                    dev_mode0,
    input  sce_pkg::sce_bus_req_t bus_req,
    output sce_pkg::sce_bus_req_t bus_fwd,
    output bit                    bus_lock
);

    import sce_pkg::*;

    core_user_t            cur_user;
    logic [`SCE_MID_W-1:0] owner_mid;
    logic                  mid_match;
    logic                  user_match;
    logic                  trust_ok;
    logic                  enable;

    // Master ID and live user word of the locked core
    assign owner_mid = owner.sel ? `SCE_MID_VEX : `SCE_MID_CM7;
    assign cur_user  = owner.sel ? core_user_vex : core_user_cm7;

    assign mid_match  = (bus_req.mid == owner_mid);

    // Core may have dropped privilege since the lock
    assign user_match = (cur_user == owner.user);

    // Secure mode also needs the key slot to be trusted
    assign trust_ok = !mode.sec || trust[bus_req.key_slot];

    assign enable = mode.non || (mid_match && user_match && trust_ok);

    // Blocked request keeps its fields, only valid drops
    always_comb begin
        bus_fwd       = bus_req;
        bus_fwd.valid = bus_req.valid && enable;
    end

    // Lock flag is masked in development mode
    assign bus_lock = dev_mode0 ? 1'b0 : !enable;

endmodule

`default_nettype wire

/* verilog/sce_guard_top.sv */
// ------------------------------
// SCE guard top level
// ------------------------------

`timescale 1ns/100ps
`default_nettype none

module sce_guard_top (
    input  bit                    clk,
    input  bit                    reset,
    input  bit [1:0]              dev_mode,
    input  bit [1:0]              sce_mode,
    input  sce_pkg::core_user_t   core_user_cm7,
    input  sce_pkg::core_user_t   core_user_vex,
    input  sce_pkg::sce_bus_req_t bus_req,
    input  sce_pkg::sce_hmac_t    hmac,
    input  bit                    ar_reset,
    input  bit                    ar_clrram,
    output sce_pkg::sce_bus_req_t bus_fwd,
    output bit                    bus_lock,
    output sce_pkg::sce_owner_t   owner,
    output sce_pkg::sce_mode_t    mode,
    output sce_pkg::sce_trust_t   trust,
    output bit                    engine_reset_n,
    output bit                    ram_clear
);

    sce_owner_ctrl u_owner_ctrl (
        .clk            (clk),
        .reset          (reset),
        .sce_mode       (sce_mode),
        .dev_mode       (dev_mode),
        .core_user_cm7  (core_user_cm7),
        .core_user_vex  (core_user_vex),
        .bus_req        (bus_req),
        .ar_reset       (ar_reset),
        .ar_clrram      (ar_clrram),
        .mode           (mode),
        .owner          (owner),
        .engine_reset_n (engine_reset_n),
        .ram_clear      (ram_clear)
    );

    sce_trust_state u_trust_state (
        .clk   (clk),
        .reset (reset),
        .mode  (mode),
        .hmac  (hmac),
        .trust (trust)
    );

    // Gate sees owner and trust as they stand this cycle
    sce_access_gate u_access_gate (
        .mode          (mode),
        .owner         (owner),
        .core_user_cm7 (core_user_cm7),
        .core_user_vex (core_user_vex),
        .trust         (trust),
        .dev_mode0     (dev_mode[0]),
        .bus_req       (bus_req),
        .bus_fwd       (bus_fwd),
        .bus_lock      (bus_lock)
    );

endmodule

`default_nettype wire

/* verification/sce_guard_checker.sv */
// ------------------------------
// SCE guard bound assertions on top-level ports
// ------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "sce_defs.svh"

module sce_guard_checker (
    input bit                    clk,
    input bit                    reset,
    input bit [1:0]              sce_mode,
    input bit                    ar_clrram,
    input bit                    ram_clear,
    input sce_pkg::sce_bus_req_t bus_req,
    input sce_pkg::sce_bus_req_t bus_fwd,
    input sce_pkg::sce_trust_t   trust,
    input sce_pkg::sce_owner_t   owner
);

    int unsigned assert_errors;
    bit [1:0]    prev_mode;
    bit          init_clear_seen;
    bit          lock_evt;

    always_ff @(posedge clk) begin
        if (reset) begin
            prev_mode       <= 2'd0;
            init_clear_seen <= 1'b0;
        end else begin
            prev_mode <= sce_mode;
            if (ram_clear && !ar_clrram) begin
                init_clear_seen <= 1'b1;
            end
        end
    end

    assign lock_evt = (prev_mode == 2'd0) && (sce_mode != prev_mode);

    // Init clear is a single pulse per reset
    a_ram_clear_once: assert property (@(posedge clk) disable iff (reset)
        (ram_clear && !ar_clrram) |-> !init_clear_seen)
        else begin
            $error("ram_clear fired a second time without ar_clrram");
            assert_errors++;
        end

    a_fwd_needs_req: assert property (@(posedge clk) bus_fwd.valid |-> bus_req.valid)
        else begin
            $error("bus_fwd.valid high without bus_req.valid");
            assert_errors++;
        end

    a_trust_top: assert property (@(posedge clk) trust[`SCE_TS_COUNT-1])
        else begin
            $error("top trust bit is low");
            assert_errors++;
        end

    // Owner may only move on the edge after leaving open mode
    a_owner_lock: assert property (@(posedge clk) disable iff (reset)
        !$stable(owner) |-> $past(lock_evt))
        else begin
            $error("owner changed without a lock event");
            assert_errors++;
        end

endmodule

`default_nettype wire

/* verification/sce_guard_tb.sv */
// ------------------------------
// SCE guard testbench with random stimulus and reference model
// ------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "sce_defs.svh"

module sce_guard_tb;

    import sce_pkg::*;

    localparam int RESET_CYCLES  = 5;
    localparam int LEN_OPEN      = 40;
    localparam int LEN_LOCK_OPEN = 10;
    localparam int LEN_LOCK_XLS  = 50;
    localparam int LEN_TRUST     = 80;
    localparam int LEN_SEC       = 60;
    localparam int LEN_RST_PRE   = 30;
    localparam int LEN_RST_POST  = 10;
    localparam int CYCLE_LIMIT   = 2 * (2 * RESET_CYCLES + LEN_OPEN + LEN_LOCK_OPEN
        + LEN_LOCK_XLS + LEN_TRUST + LEN_SEC + LEN_RST_PRE + LEN_RST_POST) + 100;

    bit           clk;
    bit           reset;
    bit [1:0]     dev_mode;
    bit [1:0]     sce_mode;
    core_user_t   core_user_cm7;
    core_user_t   core_user_vex;
    sce_bus_req_t bus_req;
    sce_hmac_t    hmac;
    bit           ar_reset;
    bit           ar_clrram;
    sce_bus_req_t bus_fwd;
    bit           bus_lock;
    sce_owner_t   owner;
    sce_mode_t    mode;
    sce_trust_t   trust;
    bit           engine_reset_n;
    bit           ram_clear;

    // Reference model state
    bit [1:0]   m_prev;
    sce_owner_t m_cand;
    sce_owner_t m_owner;
    sce_trust_t m_trust;
    int         m_init;

    core_user_t u_cm7;
    core_user_t u_vex;
    string      test_name;
    int         errors;
    int         checks;
    int         cycles;
    int         tests_run;
    int         test_errors;
    int         test_checks;

    sce_guard_top DUT (.*);

    bind sce_guard_top sce_guard_checker u_checker (.*);

    always #4 clk = !clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic check_req(input sce_bus_req_t exp, input sce_bus_req_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s bus_fwd: expected %h actual %h", test_name, exp, act);
        end
    endtask

    task automatic check_owner(input sce_owner_t exp, input sce_owner_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s owner: expected %h actual %h", test_name, exp, act);
        end
    endtask

    task automatic check_trust(input sce_trust_t exp, input sce_trust_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s trust: expected %h actual %h", test_name, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input bit exp, input bit act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s %s: expected %b actual %b", test_name, what, exp, act);
        end
    endtask

    // Expected outputs from model state and the inputs of this cycle
    task automatic check_outputs();
        sce_bus_req_t          exp_fwd;
        logic [`SCE_MID_W-1:0] own_mid;
        bit                    user_ok;
        bit                    enable;
        bit                    quit;
        own_mid = m_owner.sel ? `SCE_MID_VEX : `SCE_MID_CM7;
        user_ok = (m_owner.sel ? core_user_vex : core_user_cm7) == m_owner.user;
        enable = (sce_mode == 2'd0) || ((bus_req.mid == own_mid) && user_ok
            && (!sce_mode[1] || m_trust[bus_req.key_slot]));
        exp_fwd = bus_req;
        exp_fwd.valid = bus_req.valid && enable;
        quit = !dev_mode[1] && (m_prev != 2'd0) && (sce_mode != m_prev);
        check_req(exp_fwd, bus_fwd);
        check_bit("bus_lock", !dev_mode[0] && !enable, bus_lock);
        check_bit("mode.non", sce_mode == 2'd0, mode.non);
        check_bit("mode.xls", sce_mode == 2'd1, mode.xls);
        check_bit("mode.sec", sce_mode[1], mode.sec);
        check_owner(m_owner, owner);
        check_trust(m_trust, trust);
        check_bit("engine_reset_n", !(ar_reset || quit), engine_reset_n);
        check_bit("ram_clear", (m_init == `SCE_RAMCLR_STEPS) || ar_clrram, ram_clear);
    endtask

    task automatic model_edge();
        if (reset) begin
            m_prev  = 2'd0;
            m_cand  = '0;
            m_owner = '0;
            m_trust = {1'b1, {(`SCE_TS_COUNT-1){1'b0}}};
            m_init  = 0;
        end else begin
            // Owner takes the candidate held before this edge
            if ((m_prev == 2'd0) && (sce_mode != 2'd0))
                m_owner = m_cand;
            if (bus_req.valid && (bus_req.mid == `SCE_MID_CM7))
                m_cand = {1'b0, core_user_cm7};
            else if (bus_req.valid && (bus_req.mid == `SCE_MID_VEX))
                m_cand = {1'b1, core_user_vex};
            if (sce_mode[1] && (hmac.kid < `SCE_TS_COUNT - 1)) begin
                if (hmac.pass)
                    m_trust[hmac.kid] = 1'b1;
                else if (hmac.fail)
                    m_trust[hmac.kid] = 1'b0;
            end
            m_prev = sce_mode;
            if (m_init <= `SCE_RAMCLR_STEPS)
                m_init++;
        end
    endtask

    // Inputs are already driven, check mid-cycle then step to 1 ns past the next edge
    task automatic run_cycle();
        #2;
        check_outputs();
        @(posedge clk);
        model_edge();
        #1;
    endtask

    function automatic sce_bus_req_t rand_req(input bit core_only);
        sce_bus_req_t r;
        r.valid    = $urandom_range(0, 3) != 0;
        r.mid      = 4'($urandom);
        r.write    = 1'($urandom);
        r.key_slot = 7'($urandom);
        r.addr     = $urandom;
        r.wdata    = $urandom;
        if (core_only)
            r.mid = $urandom_range(0, 1) ? `SCE_MID_VEX : `SCE_MID_CM7;
        return r;
    endfunction

    function automatic sce_hmac_t rand_hmac();
        sce_hmac_t h;
        h.pass = 1'($urandom);
        h.fail = 1'($urandom);
        // Mostly a small key range so bits get both set and cleared
        h.kid  = ($urandom_range(0, 3) == 0) ? 10'($urandom) : 10'($urandom_range(0, 15));
        return h;
    endfunction

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
        test_checks = checks;
    endtask

    task automatic end_test();
        tests_run++;
        $display("Test %s finished: %0d checks, %0d errors", test_name,
                 checks - test_checks, errors - test_errors);
    endtask

    initial begin
        void'($urandom(32'h839bca99));
        reset         = 1'b1;
        dev_mode      = 2'd0;
        sce_mode      = 2'd0;
        core_user_cm7 = '0;
        core_user_vex = '0;
        bus_req       = '0;
        hmac          = '0;
        ar_reset      = 1'b0;
        ar_clrram     = 1'b0;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            model_edge();
        end
        #1;
        reset = 1'b0;

        start_test("open_forward");
        repeat (LEN_OPEN) begin
            dev_mode      = 2'($urandom);
            core_user_cm7 = core_user_t'($urandom);
            core_user_vex = core_user_t'($urandom);
            bus_req       = rand_req(1'b0);
            hmac          = rand_hmac();
            run_cycle();
        end
        end_test();

        start_test("owner_lock");
        u_cm7 = core_user_t'($urandom);
        u_vex = core_user_t'($urandom);
        core_user_cm7 = u_cm7;
        core_user_vex = u_vex;
        hmac = '0;
        repeat (LEN_LOCK_OPEN) begin
            dev_mode = 2'($urandom);
            bus_req  = rand_req(1'b1);
            run_cycle();
        end
        sce_mode = 2'd1;
        repeat (LEN_LOCK_XLS) begin
            dev_mode      = 2'($urandom);
            core_user_cm7 = ($urandom_range(0, 3) == 0) ? core_user_t'($urandom) : u_cm7;
            core_user_vex = ($urandom_range(0, 3) == 0) ? core_user_t'($urandom) : u_vex;
            bus_req       = rand_req($urandom_range(0, 1));
            run_cycle();
        end
        end_test();

        start_test("trust_update");
        core_user_cm7 = u_cm7;
        core_user_vex = u_vex;
        repeat (LEN_TRUST) begin
            sce_mode = 2'($urandom_range(1, 3));
            dev_mode = 2'($urandom);
            bus_req  = rand_req(1'b1);
            hmac     = rand_hmac();
            run_cycle();
        end
        end_test();

        start_test("secure_gate");
        sce_mode = 2'd2;
        hmac = '0;
        repeat (LEN_SEC) begin
            dev_mode = 2'($urandom);
            bus_req  = rand_req(1'b1);
            bus_req.key_slot = ($urandom_range(0, 7) == 0) ? 7'd127
                                                           : 7'($urandom_range(0, 15));
            run_cycle();
        end
        end_test();

        start_test("reset_clear");
        repeat (LEN_RST_PRE) begin
            if ($urandom_range(0, 2) == 0)
                sce_mode = 2'($urandom);
            dev_mode  = 2'($urandom);
            ar_reset  = $urandom_range(0, 7) == 0;
            ar_clrram = $urandom_range(0, 7) == 0;
            bus_req   = rand_req(1'b0);
            run_cycle();
        end
        ar_reset  = 1'b0;
        ar_clrram = 1'b0;
        sce_mode  = 2'd0;
        bus_req   = '0;
        reset     = 1'b1;
        repeat (RESET_CYCLES) run_cycle();
        reset = 1'b0;
        repeat (LEN_RST_POST) run_cycle();
        end_test();

        $display("Tests run: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
                 tests_run, checks, errors, DUT.u_checker.assert_errors);
        if (errors == 0 && DUT.u_checker.assert_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sce_guard.f */
+incdir+include
verilog/sce_pkg.sv
verilog/sce_owner_ctrl.sv
verilog/sce_trust_state.sv
verilog/sce_access_gate.sv
verilog/sce_guard_top.sv
verification/sce_guard_checker.sv
verification/sce_guard_tb.sv

/* Bender.yml */
package:
  name: sce_guard

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/sce_pkg.sv
      - verilog/sce_owner_ctrl.sv
      - verilog/sce_trust_state.sv
      - verilog/sce_access_gate.sv
      - verilog/sce_guard_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/sce_guard_checker.sv
      - verification/sce_guard_tb.sv
